// ==== flist.f ====
verilog/croc_lite_obi_pkg.sv
verilog/croc_lite_map_pkg.sv
verilog/obi_bus_if.sv
verilog/obi_addr_demux.sv
verilog/sram_bank.sv
verilog/obi_err_sbr.sv
verilog/soc_ctrl_regs.sv
verilog/gpio_regs.sv
verilog/croc_lite_domain.sv
sim/tb_croc_lite_domain.sv

// ==== sim/tb_croc_lite_domain.sv ====
/* Testbench for the peripheral domain top level.
   Applies a table of bus accesses back to back, then checks the SoC
   control and GPIO pins with single accesses */
`timescale 1ns/1ns

module tb_croc_lite_domain;

  localparam int unsigned GpioCount   = 16;
  localparam int unsigned WaitTimeout = 20;

  typedef logic [GpioCount-1:0] gpio_t;

  typedef struct packed {
    logic                     we;
    croc_lite_obi_pkg::addr_t addr;
    croc_lite_obi_pkg::be_t   be;
    croc_lite_obi_pkg::data_t wdata;
    croc_lite_obi_pkg::data_t exp_rdata;
    logic                     exp_err;
  } entry_t;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     fetch_en_i;
  logic                     obi_req_i;
  logic                     obi_gnt_o;
  croc_lite_obi_pkg::addr_t obi_addr_i;
  logic                     obi_we_i;
  croc_lite_obi_pkg::be_t   obi_be_i;
  croc_lite_obi_pkg::data_t obi_wdata_i;
  logic                     obi_rvalid_o;
  croc_lite_obi_pkg::data_t obi_rdata_o;
  logic                     obi_err_o;
  gpio_t                    gpio_i;
  gpio_t                    gpio_o;
  gpio_t                    gpio_out_en_o;
  gpio_t                    gpio_in_sync_o;
  logic                     gpio_irq_o;
  croc_lite_obi_pkg::addr_t boot_addr_o;
  logic                     fetch_enable_o;

  entry_t                   table_q [$];
  croc_lite_obi_pkg::data_t sram_model [croc_lite_map_pkg::SramNumWords];
  int unsigned              word_idx [6];
  logic [31:0]              lfsr_q;

  croc_lite_domain #(
    .GpioCount ( GpioCount )
  ) u_dut (
    .clk_i, .arst_n_i, .fetch_en_i,
    .obi_req_i, .obi_gnt_o, .obi_addr_i, .obi_we_i, .obi_be_i, .obi_wdata_i,
    .obi_rvalid_o, .obi_rdata_o, .obi_err_o,
    .gpio_i, .gpio_o, .gpio_out_en_o, .gpio_in_sync_o, .gpio_irq_o,
    .boot_addr_o, .fetch_enable_o
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------
  // Random data and reference model
  // --------------------------------------------------
  // Galois LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic croc_lite_obi_pkg::data_t rand_word();
    croc_lite_obi_pkg::data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic croc_lite_obi_pkg::data_t merge_bytes(
    input croc_lite_obi_pkg::data_t old_word,
    input croc_lite_obi_pkg::data_t new_word,
    input croc_lite_obi_pkg::be_t   be
  );
    croc_lite_obi_pkg::data_t w;
    w = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        w[8*i+:8] = new_word[8*i+:8];
      end
    end
    return w;
  endfunction

  function automatic croc_lite_obi_pkg::addr_t sram_addr(input int unsigned word);
    return croc_lite_map_pkg::SramBaseAddr + (word << 2);
  endfunction

  function automatic croc_lite_obi_pkg::addr_t soc_addr(input logic [11:0] offset);
    return croc_lite_map_pkg::SocCtrlBaseAddr + offset;
  endfunction

  function automatic croc_lite_obi_pkg::addr_t gpio_addr(input logic [11:0] offset);
    return croc_lite_map_pkg::GpioBaseAddr + offset;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_data(input string name, input croc_lite_obi_pkg::data_t exp,
                            input croc_lite_obi_pkg::data_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected=%b actual=%b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // Table construction
  // --------------------------------------------------
  task automatic add_entry(input logic we, input croc_lite_obi_pkg::addr_t addr,
                           input croc_lite_obi_pkg::be_t be,
                           input croc_lite_obi_pkg::data_t wdata,
                           input croc_lite_obi_pkg::data_t exp_rdata, input logic exp_err);
    entry_t e;
    e = '{we, addr, be, wdata, exp_rdata, exp_err};
    table_q.push_back(e);
  endtask

  task automatic sram_write(input int unsigned word, input croc_lite_obi_pkg::be_t be);
    croc_lite_obi_pkg::data_t wdata;
    wdata            = rand_word();
    sram_model[word] = merge_bytes(sram_model[word], wdata, be);
    add_entry(1'b1, sram_addr(word), be, wdata, '0, 1'b0);
  endtask

  task automatic sram_read(input int unsigned word);
    add_entry(1'b0, sram_addr(word), 4'hF, '0, sram_model[word], 1'b0);
  endtask

  task automatic build_table();
    // Boot address after reset
    add_entry(1'b0, soc_addr(croc_lite_map_pkg::BootAddrOffset), 4'hF, '0,
              croc_lite_map_pkg::SramBaseAddr, 1'b0);
    // Full words first and then one byte lane each with an immediate read back
    for (int k = 0; k < 6; k++) begin
      word_idx[k] = (k * 53 + 7) % croc_lite_map_pkg::SramNumWords;
      sram_write(word_idx[k], 4'hF);
    end
    for (int k = 0; k < 4; k++) begin
      sram_write(word_idx[k], 4'b0001 << k);
      sram_read(word_idx[k]);
    end
    for (int k = 0; k < 6; k++) begin
      sram_read(word_idx[k]);
    end
    // Unmapped space including just past the SRAM and SoC control spans
    add_entry(1'b1, 32'h2000_0000, 4'hF, 32'h1234_5678, croc_lite_map_pkg::ErrRspData, 1'b1);
    add_entry(1'b0, 32'h2000_0000, 4'hF, '0, croc_lite_map_pkg::ErrRspData, 1'b1);
    add_entry(1'b0, 32'h1000_0400, 4'hF, '0, croc_lite_map_pkg::ErrRspData, 1'b1);
    add_entry(1'b0, 32'h0300_1000, 4'hF, '0, croc_lite_map_pkg::ErrRspData, 1'b1);
    // Unknown register offsets read zero
    add_entry(1'b0, soc_addr(12'h008), 4'hF, '0, '0, 1'b0);
    add_entry(1'b0, gpio_addr(12'h020), 4'hF, '0, '0, 1'b0);
    // New boot address
    add_entry(1'b1, soc_addr(croc_lite_map_pkg::BootAddrOffset), 4'hF, 32'h1000_0080, '0, 1'b0);
    add_entry(1'b0, soc_addr(croc_lite_map_pkg::BootAddrOffset), 4'hF, '0, 32'h1000_0080, 1'b0);
  endtask

  // --------------------------------------------------
  // Bus access tasks start and end 1 ns after an edge
  // --------------------------------------------------
  task automatic drive_entry(input entry_t e);
    obi_req_i   = 1'b1;
    obi_we_i    = e.we;
    obi_addr_i  = e.addr;
    obi_be_i    = e.be;
    obi_wdata_i = e.wdata;
  endtask

  task automatic check_response(input entry_t e);
    check_bit("obi_rvalid_o", 1'b1, obi_rvalid_o);
    check_bit("obi_err_o", e.exp_err, obi_err_o);
    if (!e.we || e.exp_err) begin
      check_data("obi_rdata_o", e.exp_rdata, obi_rdata_o);
    end
  endtask

  // One request per cycle while the previous one is answered
  task automatic run_table();
    for (int i = 0; i <= table_q.size(); i++) begin
      if (i > 0) begin
        check_response(table_q[i-1]);
      end
      if (i < table_q.size()) begin
        drive_entry(table_q[i]);
      end else begin
        obi_req_i = 1'b0;
      end
      #1;
      check_bit("obi_gnt_o", obi_req_i, obi_gnt_o);
      @(posedge clk_i);
      #1;
    end
    // No response after the idle cycle
    check_bit("obi_rvalid_o", 1'b0, obi_rvalid_o);
  endtask

  task automatic single_access(input entry_t e);
    drive_entry(e);
    #1;
    check_bit("obi_gnt_o", 1'b1, obi_gnt_o);
    @(posedge clk_i);
    #1;
    obi_req_i = 1'b0;
    check_response(e);
  endtask

  task automatic write_reg(input croc_lite_obi_pkg::addr_t addr,
                           input croc_lite_obi_pkg::data_t wdata);
    single_access('{1'b1, addr, 4'hF, wdata, '0, 1'b0});
  endtask

  task automatic read_check(input croc_lite_obi_pkg::addr_t addr,
                            input croc_lite_obi_pkg::data_t exp);
    single_access('{1'b0, addr, 4'hF, '0, exp, 1'b0});
  endtask

  task automatic wait_in_sync(input gpio_t value);
    int unsigned cycles;
    cycles = 0;
    while (gpio_in_sync_o !== value) begin
      if (cycles == WaitTimeout) begin
        $display("Timeout: gpio_in_sync_o never reached %h", value);
        abort_run();
      end
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_irq();
    int unsigned cycles;
    cycles = 0;
    while (gpio_irq_o !== 1'b1) begin
      if (cycles == WaitTimeout) begin
        $display("Timeout: gpio_irq_o did not rise after an enabled edge");
        abort_run();
      end
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    fetch_en_i  = 1'b0;
    obi_req_i   = 1'b0;
    obi_addr_i  = '0;
    obi_we_i    = 1'b0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    gpio_i      = '0;
    lfsr_q      = 32'he40de415;

    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Reset values
    check_data("boot_addr_o", croc_lite_map_pkg::BootAddrDefault, boot_addr_o);
    check_bit("fetch_enable_o", 1'b0, fetch_enable_o);
    check_gpio("gpio_o", '0, gpio_o);
    check_gpio("gpio_out_en_o", '0, gpio_out_en_o);
    check_bit("gpio_irq_o", 1'b0, gpio_irq_o);
    check_bit("obi_rvalid_o", 1'b0, obi_rvalid_o);

    build_table();
    run_table();
    check_data("boot_addr_o", 32'h1000_0080, boot_addr_o);

    // Fetch enable needs both the register and the pin
    write_reg(soc_addr(croc_lite_map_pkg::FetchEnOffset), 32'h1);
    check_bit("fetch_enable_o", 1'b0, fetch_enable_o);
    fetch_en_i = 1'b1;
    @(posedge clk_i);
    #1;
    check_bit("fetch_enable_o", 1'b1, fetch_enable_o);
    read_check(soc_addr(croc_lite_map_pkg::FetchEnOffset), 32'h1);
    write_reg(soc_addr(croc_lite_map_pkg::FetchEnOffset), 32'h0);
    check_bit("fetch_enable_o", 1'b0, fetch_enable_o);

    // GPIO direction, output and input path
    write_reg(gpio_addr(croc_lite_map_pkg::DirOffset), 32'h0000_A5F0);
    write_reg(gpio_addr(croc_lite_map_pkg::OutOffset), 32'h0000_1234);
    check_gpio("gpio_out_en_o", 16'hA5F0, gpio_out_en_o);
    check_gpio("gpio_o", 16'h1234, gpio_o);
    gpio_i = 16'h5A3C;
    wait_in_sync(16'h5A3C);
    read_check(gpio_addr(croc_lite_map_pkg::InOffset), 32'h0000_5A3C);
    gpio_i = '0;
    wait_in_sync('0);

    // Edge interrupt on pin 3 only
    write_reg(gpio_addr(croc_lite_map_pkg::IrqEnOffset), 32'h0000_0008);
    gpio_i[5] = 1'b1;
    wait_in_sync(16'h0020);
    repeat (4) begin
      @(posedge clk_i);
      #1;
    end
    check_bit("gpio_irq_o", 1'b0, gpio_irq_o);
    gpio_i[3] = 1'b1;
    wait_irq();
    read_check(gpio_addr(croc_lite_map_pkg::IrqStatusOffset), 32'h0000_0008);
    write_reg(gpio_addr(croc_lite_map_pkg::IrqStatusOffset), 32'h0000_0008);
    check_bit("gpio_irq_o", 1'b0, gpio_irq_o);
    read_check(gpio_addr(croc_lite_map_pkg::IrqStatusOffset), 32'h0000_0000);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== verilog/croc_lite_domain.sv ====
/* Top level of the peripheral domain.
   One external bus manager reaches SRAM, SoC control, GPIO and the
   error subordinate through the address demux */
`timescale 1ns/1ns

module croc_lite_domain #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     fetch_en_i,

  // External bus manager
  input  logic                     obi_req_i,
  output logic                     obi_gnt_o,
  input  croc_lite_obi_pkg::addr_t obi_addr_i,
  input  logic                     obi_we_i,
  input  croc_lite_obi_pkg::be_t   obi_be_i,
  input  croc_lite_obi_pkg::data_t obi_wdata_i,
  output logic                     obi_rvalid_o,
  output croc_lite_obi_pkg::data_t obi_rdata_o,
  output logic                     obi_err_o,

  // GPIO pins
  input  logic [GpioCount-1:0]     gpio_i,
  output logic [GpioCount-1:0]     gpio_o,
  output logic [GpioCount-1:0]     gpio_out_en_o,
  output logic [GpioCount-1:0]     gpio_in_sync_o,
  output logic                     gpio_irq_o,

  // Core control
  output croc_lite_obi_pkg::addr_t boot_addr_o,
  output logic                     fetch_enable_o
);

  // --------------------------------------------------
  // Subordinate buses
  // --------------------------------------------------
  obi_bus_if err_bus ();
  obi_bus_if sram_bus ();
  obi_bus_if soc_ctrl_bus ();
  obi_bus_if gpio_bus ();

  obi_addr_demux u_demux (
    .clk_i,
    .arst_n_i,
    .req_i        ( obi_req_i    ),
    .gnt_o        ( obi_gnt_o    ),
    .addr_i       ( obi_addr_i   ),
    .we_i         ( obi_we_i     ),
    .be_i         ( obi_be_i     ),
    .wdata_i      ( obi_wdata_i  ),
    .rvalid_o     ( obi_rvalid_o ),
    .rdata_o      ( obi_rdata_o  ),
    .err_o        ( obi_err_o    ),
    .err_bus      ( err_bus      ),
    .sram_bus     ( sram_bus     ),
    .soc_ctrl_bus ( soc_ctrl_bus ),
    .gpio_bus     ( gpio_bus     )
  );

  // --------------------------------------------------
  // Memory and error subordinate
  // --------------------------------------------------
  sram_bank #(
    .NumWords ( croc_lite_map_pkg::SramNumWords )
  ) u_sram (
    .clk_i,
    .arst_n_i,
    .bus      ( sram_bus )
  );

  obi_err_sbr u_err (
    .clk_i,
    .arst_n_i,
    .bus      ( err_bus )
  );

  // --------------------------------------------------
  // Register blocks
  // --------------------------------------------------
  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .bus            ( soc_ctrl_bus   ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) u_gpio (
    .clk_i,
    .arst_n_i,
    .bus            ( gpio_bus   ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o )
  );

endmodule

// ==== verilog/croc_lite_map_pkg.sv ====
/* Address map of the peripheral domain.
   Holds the subordinate indices, register offsets and reset values
   used by the demux and the register blocks */
package croc_lite_map_pkg;

  // --------------------------------------------------
  // Subordinates
  // --------------------------------------------------
  localparam int unsigned NumSbr = 4;

  // Index 0 is the default target for unmapped addresses
  typedef enum logic [$clog2(NumSbr)-1:0] {
    SbrError = 0,
    SbrSram,
    SbrSocCtrl,
    SbrGpio
  } sbr_idx_e;

  // --------------------------------------------------
  // Address ranges
  // --------------------------------------------------
  localparam croc_lite_obi_pkg::addr_t SramBaseAddr      = 32'h1000_0000;
  localparam int unsigned              SramWordAddrWidth = 8;
  localparam int unsigned              SramNumWords      = 2 ** SramWordAddrWidth;

  localparam croc_lite_obi_pkg::addr_t SocCtrlBaseAddr = 32'h0300_0000;
  localparam croc_lite_obi_pkg::addr_t GpioBaseAddr    = 32'h0300_5000;
  localparam croc_lite_obi_pkg::addr_t PeriphSpan      = 32'h0000_1000;

  // --------------------------------------------------
  // Register offsets inside a 4 KiB block
  // --------------------------------------------------
  localparam int unsigned RegOffsetWidth = 12;

  localparam logic [RegOffsetWidth-1:0] BootAddrOffset  = 12'h000;
  localparam logic [RegOffsetWidth-1:0] FetchEnOffset   = 12'h004;

  localparam logic [RegOffsetWidth-1:0] DirOffset       = 12'h000;
  localparam logic [RegOffsetWidth-1:0] OutOffset       = 12'h004;
  localparam logic [RegOffsetWidth-1:0] InOffset        = 12'h008;
  localparam logic [RegOffsetWidth-1:0] IrqEnOffset     = 12'h00C;
  localparam logic [RegOffsetWidth-1:0] IrqStatusOffset = 12'h010;

  // Reset and fixed response values
  localparam croc_lite_obi_pkg::addr_t BootAddrDefault = SramBaseAddr;
  localparam croc_lite_obi_pkg::data_t ErrRspData      = 32'hBADCAB1E;

endpackage

// ==== verilog/croc_lite_obi_pkg.sv ====
/* Widths and data types of the request/grant/response bus.
   Shared by every module of the peripheral domain and by the testbench */
package croc_lite_obi_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // --------------------------------------------------
  // Bus payload types
  // --------------------------------------------------
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

endpackage

// ==== verilog/gpio_regs.sv ====
/* GPIO block with direction, output and interrupt registers.
   Inputs pass a two-flop synchronizer; rising edges on enabled pins
   set sticky status bits that are cleared by writing ones */
`timescale 1ns/1ns

module gpio_regs #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  obi_bus_if.sbr               bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  logic [croc_lite_map_pkg::RegOffsetWidth-1:0] offset;
  logic                                         wr_en;
  croc_lite_obi_pkg::data_t                     wmask;
  logic [GpioCount-1:0]                         wbits;
  logic [GpioCount-1:0]                         wvals;
  logic [GpioCount-1:0]                         dir_q;
  logic [GpioCount-1:0]                         out_q;
  logic [GpioCount-1:0]                         irq_en_q;
  logic [GpioCount-1:0]                         irq_status_q;
  logic [GpioCount-1:0]                         in_meta_q;
  logic [GpioCount-1:0]                         in_sync_q;
  logic [GpioCount-1:0]                         in_prev_q;
  logic [GpioCount-1:0]                         rise;
  logic [GpioCount-1:0]                         status_clr;
  croc_lite_obi_pkg::data_t                     rdata_d;
  croc_lite_obi_pkg::data_t                     rdata_q;
  logic                                         rvalid_q;

  assign bus.gnt = bus.req;
  assign offset  = bus.addr[croc_lite_map_pkg::RegOffsetWidth-1:0];
  assign wr_en   = bus.req && bus.gnt && bus.we;

  always_comb begin
    for (int i = 0; i < croc_lite_obi_pkg::BeWidth; i++) begin
      wmask[8*i+:8] = {8{bus.be[i]}};
    end
  end

  // Only the low GpioCount bits of a write matter
  assign wbits = wmask[GpioCount-1:0];
  assign wvals = bus.wdata[GpioCount-1:0] & wbits;

  // --------------------------------------------------
  // Input synchronizer and edge detect
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  assign rise       = in_sync_q & ~in_prev_q;
  assign status_clr = (wr_en && offset == croc_lite_map_pkg::IrqStatusOffset) ? wvals : '0;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
      if (wr_en && offset == croc_lite_map_pkg::DirOffset) begin
        dir_q <= (dir_q & ~wbits) | wvals;
      end
      if (wr_en && offset == croc_lite_map_pkg::OutOffset) begin
        out_q <= (out_q & ~wbits) | wvals;
      end
      if (wr_en && offset == croc_lite_map_pkg::IrqEnOffset) begin
        irq_en_q <= (irq_en_q & ~wbits) | wvals;
      end
      // A new edge wins over a clear in the same cycle
      irq_status_q <= (irq_status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_comb begin
    rdata_d = '0;
    case (offset)
      croc_lite_map_pkg::DirOffset:       rdata_d[GpioCount-1:0] = dir_q;
      croc_lite_map_pkg::OutOffset:       rdata_d[GpioCount-1:0] = out_q;
      croc_lite_map_pkg::InOffset:        rdata_d[GpioCount-1:0] = in_sync_q;
      croc_lite_map_pkg::IrqEnOffset:     rdata_d[GpioCount-1:0] = irq_en_q;
      croc_lite_map_pkg::IrqStatusOffset: rdata_d[GpioCount-1:0] = irq_status_q;
      default:                            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = in_sync_q;
  assign irq_o          = |(irq_status_q & irq_en_q);

endmodule

// ==== verilog/obi_addr_demux.sv ====
/* Single-manager address demux.
   Routes each request to one of four subordinates by address and
   steers the response of the accepted request back one cycle later */
`timescale 1ns/1ns

module obi_addr_demux (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     req_i,
  output logic                     gnt_o,
  input  croc_lite_obi_pkg::addr_t addr_i,
  input  logic                     we_i,
  input  croc_lite_obi_pkg::be_t   be_i,
  input  croc_lite_obi_pkg::data_t wdata_i,
  output logic                     rvalid_o,
  output croc_lite_obi_pkg::data_t rdata_o,
  output logic                     err_o,

  obi_bus_if.mgr                   err_bus,
  obi_bus_if.mgr                   sram_bus,
  obi_bus_if.mgr                   soc_ctrl_bus,
  obi_bus_if.mgr                   gpio_bus
);

  croc_lite_map_pkg::sbr_idx_e           sel;
  croc_lite_map_pkg::sbr_idx_e           sel_q;
  logic                                  rsp_valid_q;
  logic                                  sram_hit;
  logic                                  soc_ctrl_hit;
  logic                                  gpio_hit;
  logic [croc_lite_map_pkg::NumSbr-1:0]  req_all;
  logic [croc_lite_map_pkg::NumSbr-1:0]  gnt_all;
  logic [croc_lite_map_pkg::NumSbr-1:0]  rvalid_all;
  logic [croc_lite_map_pkg::NumSbr-1:0]  err_all;
  croc_lite_obi_pkg::data_t              rdata_all [croc_lite_map_pkg::NumSbr];

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // SRAM span is a power of two, compare the bits above it
  assign sram_hit = (addr_i >> (croc_lite_map_pkg::SramWordAddrWidth + 2)) ==
                    (croc_lite_map_pkg::SramBaseAddr >> (croc_lite_map_pkg::SramWordAddrWidth + 2));

  assign soc_ctrl_hit = (addr_i >= croc_lite_map_pkg::SocCtrlBaseAddr) &&
                        (addr_i <  croc_lite_map_pkg::SocCtrlBaseAddr +
                                   croc_lite_map_pkg::PeriphSpan);

  assign gpio_hit = (addr_i >= croc_lite_map_pkg::GpioBaseAddr) &&
                    (addr_i <  croc_lite_map_pkg::GpioBaseAddr + croc_lite_map_pkg::PeriphSpan);

  always_comb begin
    sel = croc_lite_map_pkg::SbrError;
    if (sram_hit) sel = croc_lite_map_pkg::SbrSram;
    if (soc_ctrl_hit) sel = croc_lite_map_pkg::SbrSocCtrl;
    if (gpio_hit) sel = croc_lite_map_pkg::SbrGpio;
  end

  // --------------------------------------------------
  // Request fanout
  // --------------------------------------------------
  always_comb begin
    req_all      = '0;
    req_all[sel] = req_i;
  end

  assign err_bus.req      = req_all[croc_lite_map_pkg::SbrError];
  assign sram_bus.req     = req_all[croc_lite_map_pkg::SbrSram];
  assign soc_ctrl_bus.req = req_all[croc_lite_map_pkg::SbrSocCtrl];
  assign gpio_bus.req     = req_all[croc_lite_map_pkg::SbrGpio];

  // Payload goes to everyone, only req is steered
  assign err_bus.addr       = addr_i;
  assign err_bus.we         = we_i;
  assign err_bus.be         = be_i;
  assign err_bus.wdata      = wdata_i;
  assign sram_bus.addr      = addr_i;
  assign sram_bus.we        = we_i;
  assign sram_bus.be        = be_i;
  assign sram_bus.wdata     = wdata_i;
  assign soc_ctrl_bus.addr  = addr_i;
  assign soc_ctrl_bus.we    = we_i;
  assign soc_ctrl_bus.be    = be_i;
  assign soc_ctrl_bus.wdata = wdata_i;
  assign gpio_bus.addr      = addr_i;
  assign gpio_bus.we        = we_i;
  assign gpio_bus.be        = be_i;
  assign gpio_bus.wdata     = wdata_i;

  // --------------------------------------------------
  // Response steering
  // --------------------------------------------------
  // Concatenation order follows the enum values
  assign gnt_all    = {gpio_bus.gnt, soc_ctrl_bus.gnt, sram_bus.gnt, err_bus.gnt};
  assign rvalid_all = {gpio_bus.rvalid, soc_ctrl_bus.rvalid, sram_bus.rvalid, err_bus.rvalid};
  assign err_all    = {gpio_bus.err, soc_ctrl_bus.err, sram_bus.err, err_bus.err};

  assign rdata_all[croc_lite_map_pkg::SbrError]   = err_bus.rdata;
  assign rdata_all[croc_lite_map_pkg::SbrSram]    = sram_bus.rdata;
  assign rdata_all[croc_lite_map_pkg::SbrSocCtrl] = soc_ctrl_bus.rdata;
  assign rdata_all[croc_lite_map_pkg::SbrGpio]    = gpio_bus.rdata;

  assign gnt_o = gnt_all[sel];

  // Remember who was addressed, its answer comes next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q       <= croc_lite_map_pkg::SbrError;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i && gnt_o;
      if (req_i && gnt_o) begin
        sel_q <= sel;
      end
    end
  end

  assign rvalid_o = rsp_valid_q && rvalid_all[sel_q];
  assign rdata_o  = rdata_all[sel_q];
  assign err_o    = err_all[sel_q];

endmodule

// ==== verilog/obi_bus_if.sv ====
/* One request/grant/response bus between the demux and a subordinate.
   The demux connects to the mgr modport, the subordinate to sbr */
`timescale 1ns/1ns

interface obi_bus_if;

  // Request channel
  logic                     req;
  logic                     gnt;
  croc_lite_obi_pkg::addr_t addr;
  logic                     we;
  croc_lite_obi_pkg::be_t   be;
  croc_lite_obi_pkg::data_t wdata;

  // Response channel, one cycle after acceptance
  logic                     rvalid;
  croc_lite_obi_pkg::data_t rdata;
  logic                     err;

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// ==== verilog/obi_err_sbr.sv ====
/* Default subordinate for unmapped addresses.
   Accepts everything and answers with an error and a fixed word */
`timescale 1ns/1ns

module obi_err_sbr (
  input  logic   clk_i,
  input  logic   arst_n_i,
  obi_bus_if.sbr bus
);

  logic rvalid_q;

  assign bus.gnt = bus.req;

  // Writes are dropped, only the response is tracked
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = croc_lite_map_pkg::ErrRspData;
  assign bus.err    = rvalid_q;

endmodule

// ==== verilog/soc_ctrl_regs.sv ====
/* SoC control registers: boot address and fetch enable.
   Fetch enable only reaches the output while the external pin agrees */
`timescale 1ns/1ns

module soc_ctrl_regs (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  obi_bus_if.sbr                   bus,
  input  logic                     fetch_en_i,
  output croc_lite_obi_pkg::addr_t boot_addr_o,
  output logic                     fetch_enable_o
);

  logic [croc_lite_map_pkg::RegOffsetWidth-1:0] offset;
  logic                                         wr_en;
  croc_lite_obi_pkg::data_t                     wmask;
  croc_lite_obi_pkg::addr_t                     boot_addr_q;
  logic                                         fetch_en_q;
  croc_lite_obi_pkg::data_t                     rdata_d;
  croc_lite_obi_pkg::data_t                     rdata_q;
  logic                                         rvalid_q;

  assign bus.gnt = bus.req;
  assign offset  = bus.addr[croc_lite_map_pkg::RegOffsetWidth-1:0];
  assign wr_en   = bus.req && bus.gnt && bus.we;

  // Byte enables widened to a bit mask
  always_comb begin
    for (int i = 0; i < croc_lite_obi_pkg::BeWidth; i++) begin
      wmask[8*i+:8] = {8{bus.be[i]}};
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= croc_lite_map_pkg::BootAddrDefault;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
      if (wr_en && offset == croc_lite_map_pkg::BootAddrOffset) begin
        boot_addr_q <= (boot_addr_q & ~wmask) | (bus.wdata & wmask);
      end
      if (wr_en && offset == croc_lite_map_pkg::FetchEnOffset && bus.be[0]) begin
        fetch_en_q <= bus.wdata[0];
      end
    end
  end

  // Read mux, unknown offsets give zero
  always_comb begin
    rdata_d = '0;
    case (offset)
      croc_lite_map_pkg::BootAddrOffset: rdata_d = boot_addr_q;
      croc_lite_map_pkg::FetchEnOffset:  rdata_d[0] = fetch_en_q;
      default:                           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q & fetch_en_i;

endmodule

// ==== verilog/sram_bank.sv ====
/* Single-port word memory with byte enables on the domain bus.
   Grants every request and answers one cycle later */
`timescale 1ns/1ns

module sram_bank #(
  parameter int unsigned NumWords = croc_lite_map_pkg::SramNumWords
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  obi_bus_if.sbr bus
);

  croc_lite_obi_pkg::data_t     mem_q [NumWords];
  croc_lite_obi_pkg::data_t     rdata_q;
  logic                         rvalid_q;
  logic [$clog2(NumWords)-1:0]  word_addr;

  // Drop the byte offset, keep the bits that index the array
  assign word_addr = bus.addr[$clog2(NumWords)+1:2];
  assign bus.gnt   = bus.req;

  // --------------------------------------------------
  // Memory array and read data
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.gnt) begin
      if (bus.we) begin
        for (int i = 0; i < croc_lite_obi_pkg::BeWidth; i++) begin
          if (bus.be[i]) begin
            mem_q[word_addr][8*i+:8] <= bus.wdata[8*i+:8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

  // One response per accepted request, reads and writes alike
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req && bus.gnt;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule
